//--- source/RobotPkg.sv
package RobotPkg;

    // Maze size
    localparam int GridRows = 10;
    localparam int GridCols = 20;
    localparam logic [3:0] LastRow = 4'(GridRows - 1);
    localparam logic [4:0] LastCol = 5'(GridCols - 1);

    // Cell codes
    localparam logic [3:0] CellWall = 4'h5;
    localparam logic [3:0] CellFree = 4'h6;

    // Row 0 on top, leftmost nibble is column 0
    localparam logic [0:GridRows-1][4*GridCols-1:0] MazeCells = {
        80'h55555555555555555555,
        80'h56665666666666665555,
        80'h56565656555555565555,
        80'h56565656666666666665,
        80'h56565656555555565555,
        80'h56566656555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56565556555555565555,
        80'h56666666666666665555
    };

    // Frame ticks between gamepad reads and between robot steps
    localparam int InputPeriod = 5;
    localparam int StepPeriod = 9;
    localparam int TickCountWidth = $clog2(StepPeriod);

    typedef enum logic [1:0] {
        HeadNorth = 2'b00,
        HeadSouth = 2'b01,
        HeadEast  = 2'b10,
        HeadWest  = 2'b11
    } heading_t;

    typedef struct packed {
        logic [3:0] row;
        logic [4:0] col;
    } gridPos_t;

    localparam gridPos_t RobotStart = '{row: 4'd3, col: 5'd18};
    localparam gridPos_t CursorStart = '{row: 4'd3, col: 5'd10};

    // Gamepad word, up at bit 0
    typedef struct packed {
        logic mode;
        logic start;
        logic z;
        logic y;
        logic x;
        logic c;
        logic b;
        logic a;
        logic right;
        logic left;
        logic down;
        logic up;
    } gamepad_t;

    // Each field holds grid coordinate plus one
    typedef struct packed {
        logic [2:0][4:0] spriteCols;
        logic [2:0][3:0] spriteRows;
    } spritePos_t;

    // Sprite field order
    localparam int SpriteBlack = 2;
    localparam int SpriteRobot = 1;
    localparam int SpriteCursor = 0;

    function automatic heading_t turnLeft(heading_t dir);
        case (dir)
            HeadNorth: return HeadWest;
            HeadWest:  return HeadSouth;
            HeadSouth: return HeadEast;
            default:   return HeadNorth;
        endcase
    endfunction

    // Off-grid neighbours wrap to out-of-range coordinates
    function automatic gridPos_t stepAhead(gridPos_t pos, heading_t dir);
        gridPos_t next;
        next = pos;
        case (dir)
            HeadNorth: next.row = pos.row - 4'd1;
            HeadSouth: next.row = pos.row + 4'd1;
            HeadEast:  next.col = pos.col + 5'd1;
            default:   next.col = pos.col - 5'd1;
        endcase
        return next;
    endfunction

endpackage

//--- source/FrameTicker.sv
`timescale 1ns/1ps

module FrameTicker
    import RobotPkg::*;
(
    input  logic Clock50,
    input  logic reset,
    input  logic vSync,
    output logic inputTick,
    output logic stepTick
);

    logic syncA;
    logic syncB;
    logic rise;
    logic [TickCountWidth-1:0] readCount;
    logic [TickCountWidth-1:0] stepCount;

    // Zero means armed, otherwise rises still to skip
    function automatic logic [TickCountWidth-1:0] nextCount(
        logic [TickCountWidth-1:0] count,
        int period
    );
        if (count == '0) begin
            return TickCountWidth'(period - 1);
        end
        return count - 1'b1;
    endfunction

    assign rise = syncA & ~syncB;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            syncA     <= 1'b0;
            syncB     <= 1'b0;
            readCount <= '0;
            stepCount <= '0;
            inputTick <= 1'b0;
            stepTick  <= 1'b0;
        end else begin
            syncA     <= vSync;
            syncB     <= syncA;
            inputTick <= rise && (readCount == '0);
            stepTick  <= rise && (stepCount == '0);
            if (rise) begin
                readCount <= nextCount(readCount, InputPeriod);
                stepCount <= nextCount(stepCount, StepPeriod);
            end
        end
    end

endmodule

//--- source/MazeMap.sv
`timescale 1ns/1ps

module MazeMap
    import RobotPkg::*;
(
    input  gridPos_t cursor,
    input  gridPos_t robotPos,
    input  heading_t heading,
    output logic     cursorFree,
    output logic     headWall,
    output logic     leftWall
);

    gridPos_t aheadPos;
    gridPos_t leftPos;
    logic [3:0] cursorCell;
    logic [3:0] aheadCell;
    logic [3:0] leftCell;

    // Anything outside the grid reads as wall
    function automatic logic [3:0] cellAt(gridPos_t pos);
        logic [4*GridCols-1:0] rowBits;
        if (pos.row >= GridRows || pos.col >= GridCols) begin
            return CellWall;
        end
        rowBits = MazeCells[pos.row];
        return rowBits[(GridCols - 1 - pos.col) * 4 +: 4];
    endfunction

    // Left neighbour is the cell ahead after a left turn
    assign aheadPos = stepAhead(robotPos, heading);
    assign leftPos  = stepAhead(robotPos, turnLeft(heading));

    assign cursorCell = cellAt(cursor);
    assign aheadCell  = cellAt(aheadPos);
    assign leftCell   = cellAt(leftPos);

    assign cursorFree = (cursorCell == CellFree);
    assign headWall   = (aheadCell == CellWall);
    assign leftWall   = (leftCell == CellWall);

endmodule

//--- source/GamepadCursor.sv
`timescale 1ns/1ps

module GamepadCursor
    import RobotPkg::*;
(
    input  logic     Clock50,
    input  logic     reset,
    input  logic     inputTick,
    input  gamepad_t pad,
    input  logic     cursorFree,
    output gridPos_t cursor,
    output logic     placeRobot,
    output logic     placeBlack
);

    // Moves held back one cycle so placement still sees the old cursor
    logic moveUp;
    logic moveDown;
    logic moveLeft;
    logic moveRight;

    always_ff @(posedge Clock50) begin
        if (reset) begin
            placeRobot <= 1'b0;
            placeBlack <= 1'b0;
            moveUp     <= 1'b0;
            moveDown   <= 1'b0;
            moveLeft   <= 1'b0;
            moveRight  <= 1'b0;
        end else begin
            // Placement only on free cells
            placeRobot <= inputTick && pad.a && cursorFree;
            placeBlack <= inputTick && pad.b && cursorFree;
            moveUp     <= inputTick && pad.up;
            moveDown   <= inputTick && pad.down;
            moveLeft   <= inputTick && pad.left;
            moveRight  <= inputTick && pad.right;
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            cursor <= CursorStart;
        end else begin
            // Down wins over up
            if (moveDown) begin
                cursor.row <= (cursor.row == LastRow) ? 4'd0 : cursor.row + 4'd1;
            end else if (moveUp) begin
                cursor.row <= (cursor.row == 4'd0) ? LastRow : cursor.row - 4'd1;
            end

            // Right wins over left
            if (moveRight) begin
                cursor.col <= (cursor.col == LastCol) ? 5'd0 : cursor.col + 5'd1;
            end else if (moveLeft) begin
                cursor.col <= (cursor.col == 5'd0) ? LastCol : cursor.col - 5'd1;
            end
        end
    end

endmodule

//--- source/RobotCore.sv
`timescale 1ns/1ps

module RobotCore
    import RobotPkg::*;
(
    input  logic     Clock50,
    input  logic     reset,
    input  logic     stepTick,
    input  logic     placeRobot,
    input  logic     placeBlack,
    input  gridPos_t cursor,
    input  logic     avancar,
    input  logic     girar,
    input  logic     headWall,
    input  logic     leftWall,
    output gridPos_t robotPos,
    output gridPos_t blackPos,
    output heading_t heading,
    output logic     head,
    output logic     left,
    output logic     under
);

    gridPos_t aheadPos;
    logic onBlack;
    logic canAdvance;

    assign aheadPos   = stepAhead(robotPos, heading);
    assign onBlack    = (robotPos == blackPos);
    // Wall ahead also covers the grid border
    assign canAdvance = avancar && !headWall;

    // Sensors reflect the state before the step
    always_ff @(posedge Clock50) begin
        if (reset) begin
            head  <= 1'b0;
            left  <= 1'b0;
            under <= 1'b0;
        end else if (stepTick) begin
            head  <= headWall;
            left  <= leftWall;
            under <= onBlack;
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            heading <= HeadEast;
        end else if (stepTick && !avancar && girar) begin
            heading <= turnLeft(heading);
        end
    end

    always_ff @(posedge Clock50) begin
        if (reset) begin
            robotPos <= RobotStart;
        end else begin
            if (stepTick && canAdvance) begin
                robotPos <= aheadPos;
            end
            // Placement overrides a step on the same edge
            if (placeRobot) begin
                robotPos <= cursor;
            end
        end
    end

    // Black cell starts under the robot
    always_ff @(posedge Clock50) begin
        if (reset) begin
            blackPos <= RobotStart;
        end else if (placeBlack) begin
            blackPos <= cursor;
        end
    end

endmodule

//--- source/RobotController.sv
`timescale 1ns/1ps

module RobotController
    import RobotPkg::*;
(
    input  logic       Clock50,
    input  logic       reset,
    input  logic       vSync,
    input  gamepad_t   pad,
    input  logic       avancar,
    input  logic       girar,
    output logic       head,
    output logic       left,
    output logic       under,
    output spritePos_t sprites,
    output heading_t   heading
);

    logic inputTick;
    logic stepTick;
    logic placeRobot;
    logic placeBlack;
    logic cursorFree;
    logic headWall;
    logic leftWall;
    gridPos_t cursor;
    gridPos_t robotPos;
    gridPos_t blackPos;

    FrameTicker u_ticker (
        .Clock50   (Clock50),
        .reset     (reset),
        .vSync     (vSync),
        .inputTick (inputTick),
        .stepTick  (stepTick)
    );

    MazeMap u_maze (
        .cursor     (cursor),
        .robotPos   (robotPos),
        .heading    (heading),
        .cursorFree (cursorFree),
        .headWall   (headWall),
        .leftWall   (leftWall)
    );

    GamepadCursor u_cursor (
        .Clock50    (Clock50),
        .reset      (reset),
        .inputTick  (inputTick),
        .pad        (pad),
        .cursorFree (cursorFree),
        .cursor     (cursor),
        .placeRobot (placeRobot),
        .placeBlack (placeBlack)
    );

    RobotCore u_core (
        .Clock50    (Clock50),
        .reset      (reset),
        .stepTick   (stepTick),
        .placeRobot (placeRobot),
        .placeBlack (placeBlack),
        .cursor     (cursor),
        .avancar    (avancar),
        .girar      (girar),
        .headWall   (headWall),
        .leftWall   (leftWall),
        .robotPos   (robotPos),
        .blackPos   (blackPos),
        .heading    (heading),
        .head       (head),
        .left       (left),
        .under      (under)
    );

    // Sprite display counts from one
    always_ff @(posedge Clock50) begin
        sprites.spriteCols[SpriteBlack]  <= blackPos.col + 5'd1;
        sprites.spriteCols[SpriteRobot]  <= robotPos.col + 5'd1;
        sprites.spriteCols[SpriteCursor] <= cursor.col + 5'd1;
        sprites.spriteRows[SpriteBlack]  <= blackPos.row + 4'd1;
        sprites.spriteRows[SpriteRobot]  <= robotPos.row + 4'd1;
        sprites.spriteRows[SpriteCursor] <= cursor.row + 4'd1;
    end

endmodule

//--- test/RobotControllerTb.sv
`timescale 1ns/1ps

module RobotControllerTb
    import RobotPkg::*;
();

    localparam int ResetCycles = 16;
    localparam int FramePeriod = 20;
    localparam int PulseHigh = 4;
    localparam int SettleCycles = 10;
    localparam int TimeoutMargin = 200;
    localparam string StimulusPath = "test/robot_stimulus.txt";

    // One line of the stimulus file, sprite values are coordinate plus one
    typedef struct packed {
        gamepad_t    pad;
        logic        avancar;
        logic        girar;
        logic [15:0] frames;
        logic [3:0]  robotRow;
        logic [4:0]  robotCol;
        logic [3:0]  blackRow;
        logic [4:0]  blackCol;
        logic [3:0]  cursorRow;
        logic [4:0]  cursorCol;
        logic [1:0]  heading;
        logic        head;
        logic        left;
        logic        under;
    } testVec_t;

    logic       Clock50;
    logic       reset;
    logic       vSync;
    gamepad_t   pad;
    logic       avancar;
    logic       girar;
    logic       head;
    logic       left;
    logic       under;
    spritePos_t sprites;
    heading_t   heading;

    testVec_t tests[$];
    int totalFrames;
    int errorCount;
    int passCount;
    int failCount;
    int cycleCount;
    int cycleLimit;
    bit limitReady;

    RobotController u_dut (
        .Clock50 (Clock50),
        .reset   (reset),
        .vSync   (vSync),
        .pad     (pad),
        .avancar (avancar),
        .girar   (girar),
        .head    (head),
        .left    (left),
        .under   (under),
        .sprites (sprites),
        .heading (heading)
    );

    always #10 Clock50 = ~Clock50;

    // Run limit from the frame counts in the stimulus file
    always @(posedge Clock50) begin
        cycleCount <= cycleCount + 1;
        if (limitReady && cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR t=%0t %s: got %0d expected %0d", $time, name, got, expected);
            errorCount++;
        end
    endtask

    task automatic readStimulus();
        int fd;
        int fields;
        int lineNo;
        int f[14];
        string line;
        testVec_t vec;
        fd = $fopen(StimulusPath, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", StimulusPath);
            errorCount++;
            return;
        end
        lineNo = 0;
        while ($fgets(line, fd) > 0) begin
            lineNo++;
            // Skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %d %d %d %d %d %d %d %d %d %d %d %d %d",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                             f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
            if (fields != 14) begin
                $display("Stimulus line %0d has %0d fields instead of 14", lineNo, fields);
                errorCount++;
                continue;
            end
            vec.pad       = 12'(f[0]);
            vec.avancar   = f[1][0];
            vec.girar     = f[2][0];
            vec.frames    = 16'(f[3]);
            vec.robotRow  = 4'(f[4]);
            vec.robotCol  = 5'(f[5]);
            vec.blackRow  = 4'(f[6]);
            vec.blackCol  = 5'(f[7]);
            vec.cursorRow = 4'(f[8]);
            vec.cursorCol = 5'(f[9]);
            vec.heading   = 2'(f[10]);
            vec.head      = f[11][0];
            vec.left      = f[12][0];
            vec.under     = f[13][0];
            tests.push_back(vec);
            totalFrames += f[3];
        end
        $fclose(fd);
    endtask

    // One vSync pulse per frame
    task automatic sendFrame();
        vSync <= 1'b1;
        repeat (PulseHigh) @(posedge Clock50);
        vSync <= 1'b0;
        repeat (FramePeriod - PulseHigh) @(posedge Clock50);
    endtask

    task automatic runTest(input testVec_t vec, input int index);
        int errorsBefore;
        errorsBefore = errorCount;
        @(posedge Clock50);
        pad     <= vec.pad;
        avancar <= vec.avancar;
        girar   <= vec.girar;
        repeat (vec.frames) sendFrame();
        repeat (SettleCycles) @(posedge Clock50);
        // Outputs are settled well before this edge
        @(negedge Clock50);
        compareValue("robotRow", sprites.spriteRows[SpriteRobot], vec.robotRow);
        compareValue("robotCol", sprites.spriteCols[SpriteRobot], vec.robotCol);
        compareValue("blackRow", sprites.spriteRows[SpriteBlack], vec.blackRow);
        compareValue("blackCol", sprites.spriteCols[SpriteBlack], vec.blackCol);
        compareValue("cursorRow", sprites.spriteRows[SpriteCursor], vec.cursorRow);
        compareValue("cursorCol", sprites.spriteCols[SpriteCursor], vec.cursorCol);
        compareValue("heading", heading, vec.heading);
        compareValue("head", head, vec.head);
        compareValue("left", left, vec.left);
        compareValue("under", under, vec.under);
        if (errorCount == errorsBefore) begin
            $display("Test %0d done after %0d frames: ok", index, vec.frames);
            passCount++;
        end else begin
            $display("Test %0d done after %0d frames: %0d mismatches", index, vec.frames,
                     errorCount - errorsBefore);
            failCount++;
        end
    endtask

    initial begin
        Clock50 = 1'b0;
        reset = 1'b1;
        vSync = 1'b0;
        pad = '0;
        avancar = 1'b0;
        girar = 1'b0;
        totalFrames = 0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        cycleCount = 0;
        limitReady = 1'b0;

        readStimulus();
        if (tests.size() == 0) begin
            $display("No test vectors were read from the stimulus file");
            errorCount++;
        end
        cycleLimit = ResetCycles + totalFrames * FramePeriod
                   + tests.size() * (SettleCycles + 4) + TimeoutMargin;
        limitReady = 1'b1;

        repeat (ResetCycles) @(posedge Clock50);
        reset <= 1'b0;

        for (int i = 0; i < tests.size(); i++) begin
            runTest(tests[i], i + 1);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests.size(), passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/RobotPkg.sv
source/FrameTicker.sv
source/MazeMap.sv
source/GamepadCursor.sv
source/RobotCore.sv
source/RobotController.sv
test/RobotControllerTb.sv

//--- Makefile
TOOL      = verilator
TOP       = RobotControllerTb
FILELIST  = verilog.f
FLAGS     = --binary --timing -j 0 -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/robot_stimulus.txt
# pad(hex) avancar girar frames robotRow robotCol blackRow blackCol cursorRow cursorCol
# then heading (N=0 S=1 E=2 W=3) head left under; sprite values are grid coordinate plus one
000 0 0 0   4 19  4 19  4 11  2 0 0 0
004 0 0 1   4 19  4 19  4 10  2 1 1 1
004 0 0 50  4 19  4 19  4 20  2 1 1 1
001 0 0 20  4 19  4 19  10 20  2 1 1 1
010 0 0 5   4 19  4 19  10 20  2 1 1 1
004 0 0 20  4 19  4 19  10 16  2 1 1 1
020 0 0 5   4 19  10 16  10 16  2 1 1 1
000 0 1 8   4 19  10 16  10 16  0 1 1 0
000 0 1 9   4 19  10 16  10 16  3 1 0 0
000 0 1 9   4 19  10 16  10 16  1 0 1 0
000 0 1 9   4 19  10 16  10 16  2 1 1 0
000 0 1 9   4 19  10 16  10 16  0 1 1 0
000 0 1 9   4 19  10 16  10 16  3 1 0 0
000 1 0 9   4 18  10 16  10 16  3 0 1 0
000 1 0 27  4 15  10 16  10 16  3 0 0 0
000 1 0 63  4 8   10 16  10 16  3 0 1 0
000 1 0 9   4 8   10 16  10 16  3 1 0 0
010 0 0 4   10 16  10 16  10 16  3 1 0 0
000 0 0 5   10 16  10 16  10 16  3 0 1 1
000 0 1 9   10 16  10 16  10 16  1 0 1 1
000 1 0 9   10 16  10 16  10 16  1 1 1 1
008 0 0 22  10 16  10 16  10 1  1 1 1 1
002 0 0 5   10 16  10 16  1 1  1 1 1 1
00a 0 0 5   10 16  10 16  2 2  1 1 1 1
018 0 0 5   2 2  10 16  2 3  1 1 1 1
000 1 0 8   3 2  10 16  2 3  1 0 0 0
